/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_lsuTop
FILELIST  ?= sim.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hw/*.sv test/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/boundaryModeRegs.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module boundaryModeRegs (
  input  logic                            iClk,
  input  logic                            rstN,
  input  logic                            specialWrite,   // cp store to the page
  input  logic                            specialRead,    // cp load from the page
  input  logic [`LSU_REG_OFFSET_BITS-1:0] regOffset,
  input  logic [`LSU_DATA_WIDTH-1:0]      writeData,      // cp store data
  output logic [`LSU_DATA_WIDTH-1:0]      readData,       // one cycle after the read
  output lsu_pkg::boundaryMode_t          boundaryModeFirst,
  output lsu_pkg::boundaryMode_t          boundaryModeLast
);

  lsu_pkg::boundaryMode_t modeFirst;
  lsu_pkg::boundaryMode_t modeLast;
  lsu_pkg::boundaryMode_t modeSel;   // mode picked by the read offset

  // ======================================================================
  // register write
  // ======================================================================
  always_ff @(posedge iClk) begin
    if (!rstN) begin
      modeFirst <= `LSU_BOUNDARY_ZERO;
      modeLast  <= `LSU_BOUNDARY_ZERO;
    end else if (specialWrite) begin
      // only the low two bits are kept
      if (regOffset == `LSU_BOUNDARY_FIRST_ADDR)
        modeFirst <= writeData[1:0];
      if (regOffset == `LSU_BOUNDARY_LAST_ADDR)
        modeLast  <= writeData[1:0];
      // unmapped offset drops the write
    end
  end

  // first only on an exact match, last for everything else
  assign modeSel = (regOffset == `LSU_BOUNDARY_FIRST_ADDR) ? modeFirst : modeLast;

  // ======================================================================
  // registered read port
  // ======================================================================
  always_ff @(posedge iClk) begin
    if (!rstN) begin
      readData <= '0;
    end else if (specialRead) begin
      readData <= {{(`LSU_DATA_WIDTH-2){1'b0}}, modeSel};   // zero-extended
    end
  end

  assign boundaryModeFirst = modeFirst;   // to the first pe
  assign boundaryModeLast  = modeLast;    // to the last pe

  // one cp request per cycle, so the page sees a load or a store
  aNoWriteAndRead: assert property (
    @(posedge iClk) disable iff (!rstN)
    !(specialWrite && specialRead)
  ) else $error("boundaryModeRegs: special write and read together");

endmodule

/* hw/loadAligner.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module loadAligner (
  input  logic                       iClk,
  input  logic                       rstN,
  input  lsu_pkg::loadTag_t          tag,          // tag of the current request
  input  logic                       tagLoad,      // read issued this cycle
  input  logic [`LSU_DATA_WIDTH-1:0] memData,      // dmem read data, one cycle later
  input  logic [`LSU_DATA_WIDTH-1:0] specialData,  // special reg read data
  output logic [`LSU_DATA_WIDTH-1:0] loadData      // aligned load result
);

  lsu_pkg::loadTag_t          tagQ;      // tag of the load in flight
  logic [`LSU_DATA_WIDTH-1:0] aligned;   // memory word after extraction

  // ======================================================================
  // tag register, rewritten on every read
  // ======================================================================
  always_ff @(posedge iClk) begin
    if (!rstN) begin
      tagQ <= '0;                 // word, not special
    end else if (tagLoad) begin
      tagQ <= tag;
    end
  end

  // ======================================================================
  // byte/half-word extraction, zero-extended
  // ======================================================================
  always_comb begin
    case (tagQ.opcode)
      lsu_pkg::opWord: begin
        aligned = memData;
      end
      lsu_pkg::opHalf: begin
        // offset bit 1 picks the upper half
        if (tagQ.offset[1])
          aligned = {16'b0, memData[31:16]};
        else
          aligned = {16'b0, memData[15:0]};
      end
      lsu_pkg::opByte: begin
        case (tagQ.offset)
          2'b00:   aligned = {24'b0, memData[7:0]};
          2'b01:   aligned = {24'b0, memData[15:8]};
          2'b10:   aligned = {24'b0, memData[23:16]};
          default: aligned = {24'b0, memData[31:24]};
        endcase
      end
      default: begin
        aligned = memData;        // undefined opcode, pass word
      end
    endcase
  end

  // special page loads ignore whatever dmem returned
  assign loadData = tagQ.special ? specialData : aligned;

  // the captured opcode comes from the agu and must be one of the three widths
  aOpcodeDefined: assert property (
    @(posedge iClk) disable iff (!rstN)
    tagQ.opcode inside {lsu_pkg::opWord, lsu_pkg::opHalf, lsu_pkg::opByte}
  ) else $error("loadAligner: undefined opcode in load tag");

endmodule

/* hw/lsuRequest.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuRequest #(
  parameter bit hasSpecialPage = 1'b0   // 1 on the cp lane only
) (
  input  logic                             iClk,
  input  logic                             rstN,
  input  lsu_pkg::aguReq_t                 agu,           // from the core agu
  output lsu_pkg::dmemReq_t                dmem,          // to the data memory
  output lsu_pkg::loadTag_t                tag,           // to the load aligner
  output logic                             tagLoad,       // capture tag this cycle
  output logic                             specialWrite,  // store to a special reg
  output logic                             specialRead,   // load from a special reg
  output logic [`LSU_REG_OFFSET_BITS-1:0]  regOffset
);

  logic isSpecial;   // access hits the special page
  logic memWrite;    // write enable after the page decode

  // page tag all ones, only where the page exists
  assign isSpecial = hasSpecialPage &&
                     (agu.addr.special.page == `LSU_SPECIAL_PAGE);

  // stores to the page never reach dmem
  assign memWrite = agu.writeEnable & ~isSpecial;

  // ======================================================================
  // memory request, same cycle as the agu request
  // ======================================================================
  always_comb begin
    dmem.writeEnable = memWrite;
    dmem.readEnable  = agu.readEnable;             // special reads still go out
    dmem.valid       = memWrite | agu.readEnable;
    dmem.byteSelect  = agu.byteSelect;
    dmem.wordAddr    = agu.addr.mem.wordIndex[`LSU_RAM_ADDR_BITS-1:0];
    dmem.writeData   = agu.storeData;
  end

  // load tag, held by the aligner on every read
  always_comb begin
    tag.opcode  = agu.opcode;
    tag.offset  = agu.addr.mem.byteOffset;
    tag.special = isSpecial;
  end

  assign tagLoad = agu.readEnable;

  // special register file strobes
  assign specialWrite = isSpecial & agu.writeEnable;
  assign specialRead  = isSpecial & agu.readEnable;
  assign regOffset    = agu.addr.special.regOffset;

  // the core issues either a load or a store per cycle, never both
  aNoReadWrite: assert property (
    @(posedge iClk) disable iff (!rstN)
    !(agu.readEnable && agu.writeEnable)
  ) else $error("lsuRequest: read and write enabled together");

endmodule

/* hw/lsuTop.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuTop (
  input  logic                       iClk,
  input  logic                       rstN,

  // agu requests from the cores
  input  lsu_pkg::aguReq_t           cpReq,
  input  lsu_pkg::aguReq_t           peReq [`LSU_NUM_PE],

  // data memory requests
  output lsu_pkg::dmemReq_t          cpDmem,
  output lsu_pkg::dmemReq_t          peDmem [`LSU_NUM_PE],

  // data memory read data, one cycle after the read
  input  logic [`LSU_DATA_WIDTH-1:0] cpMemData,
  input  logic [`LSU_DATA_WIDTH-1:0] peMemData [`LSU_NUM_PE],

  // aligned load data back to the cores
  output logic [`LSU_DATA_WIDTH-1:0] cpLoadData,
  output logic [`LSU_DATA_WIDTH-1:0] peLoadData [`LSU_NUM_PE],

  // boundary modes to the pe array
  output lsu_pkg::boundaryMode_t     boundaryModeFirst,
  output lsu_pkg::boundaryMode_t     boundaryModeLast
);

  // cp lane internals
  lsu_pkg::loadTag_t               cpTag;
  logic                            cpTagLoad;
  logic                            specialWrite;
  logic                            specialRead;
  logic [`LSU_REG_OFFSET_BITS-1:0] regOffset;
  logic [`LSU_DATA_WIDTH-1:0]      specialData;   // regs to cp aligner

  // pe lane internals
  lsu_pkg::loadTag_t               peTag     [`LSU_NUM_PE];
  logic                            peTagLoad [`LSU_NUM_PE];

  // ======================================================================
  // cp lane
  // ======================================================================
  lsuRequest #(
    .hasSpecialPage (1'b1)
  ) cpRequest_i (
    .iClk         (iClk),
    .rstN         (rstN),
    .agu          (cpReq),
    .dmem         (cpDmem),
    .tag          (cpTag),
    .tagLoad      (cpTagLoad),
    .specialWrite (specialWrite),
    .specialRead  (specialRead),
    .regOffset    (regOffset)
  );

  boundaryModeRegs boundaryModeRegs_i (
    .iClk              (iClk),
    .rstN              (rstN),
    .specialWrite      (specialWrite),
    .specialRead       (specialRead),
    .regOffset         (regOffset),
    .writeData         (cpReq.storeData),   // raw store data, page writes skip dmem
    .readData          (specialData),
    .boundaryModeFirst (boundaryModeFirst),
    .boundaryModeLast  (boundaryModeLast)
  );

  loadAligner cpAligner_i (
    .iClk        (iClk),
    .rstN        (rstN),
    .tag         (cpTag),
    .tagLoad     (cpTagLoad),
    .memData     (cpMemData),
    .specialData (specialData),
    .loadData    (cpLoadData)
  );

  // ======================================================================
  // pe lanes, no special page
  // ======================================================================
  for (genvar i = 0; i < `LSU_NUM_PE; i++) begin : gPeLane
    lsuRequest #(
      .hasSpecialPage (1'b0)
    ) peRequest_i (
      .iClk         (iClk),
      .rstN         (rstN),
      .agu          (peReq[i]),
      .dmem         (peDmem[i]),
      .tag          (peTag[i]),
      .tagLoad      (peTagLoad[i]),
      .specialWrite (),            // always low on a pe lane
      .specialRead  (),
      .regOffset    ()
    );

    loadAligner peAligner_i (
      .iClk        (iClk),
      .rstN        (rstN),
      .tag         (peTag[i]),
      .tagLoad     (peTagLoad[i]),
      .memData     (peMemData[i]),
      .specialData ('0),             // special bit never set here
      .loadData    (peLoadData[i])
    );
  end

endmodule

/* hw/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

  // ======================================================================
  // load/store width
  // ======================================================================
  typedef enum logic [1:0] {
    opWord = 2'b00,   // zero value, so a cleared tag means word
    opHalf = 2'b01,
    opByte = 2'b10
  } lsuOp_e;

  // boundary handling mode for the first/last pe
  typedef logic [1:0] boundaryMode_t;

  // ======================================================================
  // agu byte address, two views of one word
  // ======================================================================
  typedef struct packed {
    logic [`LSU_DATA_WIDTH-3:0] wordIndex;    // word index into dmem
    logic [1:0]                 byteOffset;   // byte inside the word
  } memAddr_t;

  typedef struct packed {
    logic [`LSU_PAGE_BITS-1:0]       page;       // all ones on the special page
    logic [`LSU_REG_OFFSET_BITS-1:0] regOffset;  // which special register
  } specialAddr_t;

  typedef union packed {
    memAddr_t     mem;       // normal dmem access
    specialAddr_t special;   // memory-mapped register access
  } cpuAddr_u;

  // request straight from the agu
  typedef struct packed {
    logic                         writeEnable;
    logic                         readEnable;
    lsuOp_e                       opcode;       // word/half/byte
    logic [`LSU_DATA_WIDTH/8-1:0] byteSelect;
    cpuAddr_u                     addr;         // byte address
    logic [`LSU_DATA_WIDTH-1:0]   storeData;
  } aguReq_t;

  // request as seen by the data memory
  typedef struct packed {
    logic                          valid;        // read or write
    logic                          writeEnable;
    logic                          readEnable;
    logic [`LSU_DATA_WIDTH/8-1:0]  byteSelect;
    logic [`LSU_RAM_ADDR_BITS-1:0] wordAddr;
    logic [`LSU_DATA_WIDTH-1:0]    writeData;
  } dmemReq_t;

  // what a load needs to know one cycle later
  typedef struct packed {
    lsuOp_e     opcode;
    logic [1:0] offset;    // byte offset of the load
    logic       special;   // answer from the special regs, not dmem
  } loadTag_t;

endpackage

/* include/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ======================================================================
// lane geometry
// ======================================================================

`define LSU_DATA_WIDTH        32      // lane data width, cp and pe alike
`define LSU_RAM_ADDR_BITS     10      // word address into each dmem
`define LSU_NUM_PE            4       // pe lanes next to the single cp lane

// byte address split for the special page view
`define LSU_PAGE_BITS         24      // upper address bits, the page tag
`define LSU_REG_OFFSET_BITS   8       // register offset inside the page

// ======================================================================
// special page
// ======================================================================

// 0xffff_ff00 .. 0xffff_ffff, cp lane only
`define LSU_SPECIAL_PAGE      24'hff_ffff

// register offsets within the page
`define LSU_BOUNDARY_FIRST_ADDR  8'h00   // boundary mode of the first pe
`define LSU_BOUNDARY_LAST_ADDR   8'h04   // boundary mode of the last pe

// boundary mode after reset
`define LSU_BOUNDARY_ZERO     2'b00

`endif

/* sim.f */
+incdir+include
hw/lsu_pkg.sv
hw/lsuRequest.sv
hw/boundaryModeRegs.sv
hw/loadAligner.sv
hw/lsuTop.sv
test/tb_lsuTop.sv

/* test/tb_lsuTop.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsuTop;

  localparam int Lanes   = `LSU_NUM_PE + 1;   // lane 0 is the cp
  localparam int Timeout = 16;                 // cycles allowed for read data

  logic                       iClk;
  logic                       rstN;
  lsu_pkg::aguReq_t           cpReq;
  lsu_pkg::aguReq_t           peReq      [`LSU_NUM_PE];
  lsu_pkg::dmemReq_t          cpDmem;
  lsu_pkg::dmemReq_t          peDmem     [`LSU_NUM_PE];
  logic [`LSU_DATA_WIDTH-1:0] cpMemData;
  logic [`LSU_DATA_WIDTH-1:0] peMemData  [`LSU_NUM_PE];
  logic [`LSU_DATA_WIDTH-1:0] cpLoadData;
  logic [`LSU_DATA_WIDTH-1:0] peLoadData [`LSU_NUM_PE];
  lsu_pkg::boundaryMode_t     boundaryModeFirst;
  lsu_pkg::boundaryMode_t     boundaryModeLast;

  // per-lane memory model with a read port only
  logic [31:0]       mem      [Lanes][1 << `LSU_RAM_ADDR_BITS];
  logic [31:0]       memData  [Lanes];
  logic              rdValid  [Lanes];   // memData answers a read this cycle
  lsu_pkg::dmemReq_t dmemLane [Lanes];

  logic [31:0]            rngState;
  lsu_pkg::boundaryMode_t expFirst;        // modes the dut should hold
  lsu_pkg::boundaryMode_t expLast;
  lsu_pkg::aguReq_t       burstReq [4];    // loads issued back to back
  logic [31:0]            burstExp [4];
  int testErrors;
  int totalErrors;
  int testsRun;
  int testsFailed;

  lsuTop dut_i (.*);

  initial begin
    iClk = 1'b0;
    forever #10 iClk = ~iClk;
  end

  // ====================================================================
  // memory model
  // ====================================================================
  always_comb begin
    dmemLane[0] = cpDmem;
    cpMemData   = memData[0];
    for (int i = 0; i < `LSU_NUM_PE; i++) begin
      dmemLane[i+1] = peDmem[i];
      peMemData[i]  = memData[i+1];
    end
  end

  always @(posedge iClk) begin
    for (int l = 0; l < Lanes; l++) begin
      if (!rstN) begin
        memData[l] <= '0;
        rdValid[l] <= 1'b0;
      end else begin
        rdValid[l] <= dmemLane[l].readEnable;   // one cycle read latency
        if (dmemLane[l].readEnable)
          memData[l] <= mem[l][dmemLane[l].wordAddr];
      end
    end
  end

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // random byte address that never lands on the special page
  function automatic logic [31:0] randomAddr(input logic [1:0] off);
    rngState = xorshift32(rngState);
    return {1'b0, rngState[30:12], rngState[9:0], off};
  endfunction

  function automatic lsu_pkg::lsuOp_e opFor(input int i);
    case (i % 3)
      0:       return lsu_pkg::opWord;
      1:       return lsu_pkg::opHalf;
      default: return lsu_pkg::opByte;
    endcase
  endfunction

  // zero-extended slice of the memory word that a load must return
  function automatic logic [31:0] expectedLoad(input logic [31:0] word,
                                               input lsu_pkg::lsuOp_e op,
                                               input logic [1:0] off);
    case (op)
      lsu_pkg::opHalf: return (word >> (off[1] ? 16 : 0)) & 32'h0000_ffff;
      lsu_pkg::opByte: return (word >> (8 * off)) & 32'h0000_00ff;
      default:         return word;
    endcase
  endfunction

  function automatic lsu_pkg::dmemReq_t expectedDmem(input lsu_pkg::aguReq_t r,
                                                     input logic special);
    lsu_pkg::dmemReq_t d;
    logic [31:0]       raw;
    raw           = r.addr;
    d.writeEnable = r.writeEnable && !special;   // page stores stay off dmem
    d.readEnable  = r.readEnable;
    d.valid       = d.writeEnable || d.readEnable;
    d.byteSelect  = r.byteSelect;
    d.wordAddr    = raw[2 +: `LSU_RAM_ADDR_BITS];
    d.writeData   = r.storeData;
    return d;
  endfunction

  function automatic lsu_pkg::aguReq_t makeLoad(input lsu_pkg::lsuOp_e op,
                                                input logic [31:0] a);
    lsu_pkg::aguReq_t r;
    r            = '0;
    r.readEnable = 1'b1;
    r.opcode     = op;
    r.byteSelect = 4'hf;
    r.addr       = a;
    return r;
  endfunction

  function automatic logic [31:0] loadOf(input int lane);
    if (lane == 0)
      return cpLoadData;
    else
      return peLoadData[lane-1];
  endfunction

  // call right after a rising edge
  task automatic setReq(input int lane, input lsu_pkg::aguReq_t r);
    if (lane == 0)
      cpReq <= r;
    else
      peReq[lane-1] <= r;
  endtask

  task automatic checkDmemReq(input string name, input lsu_pkg::dmemReq_t exp,
                              input lsu_pkg::dmemReq_t act);
    if (act !== exp) begin
      testErrors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkLoad(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (act !== exp) begin
      testErrors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkMode(input string name, input lsu_pkg::boundaryMode_t exp,
                           input lsu_pkg::boundaryMode_t act);
    if (act !== exp) begin
      testErrors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic endTest(input string name);
    testsRun++;
    totalErrors += testErrors;
    if (testErrors == 0) begin
      $display("%s: ok", name);
    end else begin
      testsFailed++;
      $display("%s: FAILED, %0d mismatches", name, testErrors);
    end
    testErrors = 0;
  endtask

  // next falling edge where the model flags returned read data
  task automatic waitReadReturn(input int lane);
    int cyc;
    cyc = 0;
    @(negedge iClk);
    while (!rdValid[lane] && cyc < Timeout) begin
      cyc++;
      @(negedge iClk);
    end
    if (!rdValid[lane]) begin
      testErrors++;
      $display("timeout: lane %0d returned no read data in %0d cycles", lane, Timeout);
    end
  endtask

  // issue burstReq[0..n-1] on consecutive edges and check each a cycle later
  task automatic loadBurst(input int lane, input int n, input string name);
    for (int k = 0; k <= n; k++) begin
      @(posedge iClk);
      if (k < n)
        setReq(lane, burstReq[k]);
      else
        setReq(lane, '0);
      if (k > 0) begin
        waitReadReturn(lane);
        checkLoad(name, burstExp[k-1], loadOf(lane));
      end
    end
  endtask

  task automatic specialStore(input logic [7:0] off, input logic [31:0] data);
    lsu_pkg::aguReq_t r;
    r             = '0;
    r.writeEnable = 1'b1;
    r.byteSelect  = 4'hf;
    r.addr        = {`LSU_SPECIAL_PAGE, off};
    r.storeData   = data;
    @(posedge iClk);
    setReq(0, r);
    @(negedge iClk);
    checkDmemReq("specialWrite dmem", expectedDmem(r, 1'b1), cpDmem);
    if (off == `LSU_BOUNDARY_FIRST_ADDR)
      expFirst = data[1:0];
    else if (off == `LSU_BOUNDARY_LAST_ADDR)
      expLast = data[1:0];
    @(posedge iClk);
    setReq(0, '0);
    @(negedge iClk);                                     // mode updated at the store edge
    checkMode("specialWrite first", expFirst, boundaryModeFirst);
    checkMode("specialWrite last", expLast, boundaryModeLast);
  endtask

  // ====================================================================
  // tests
  // ====================================================================
  task automatic testReset;
    @(negedge iClk);
    for (int l = 0; l < Lanes; l++)
      checkDmemReq("reset", '0, dmemLane[l]);          // idle inputs leave everything low
    checkMode("reset first", `LSU_BOUNDARY_ZERO, boundaryModeFirst);
    checkMode("reset last", `LSU_BOUNDARY_ZERO, boundaryModeLast);
    endTest("reset");
  endtask

  task automatic testRequestDecode;
    lsu_pkg::aguReq_t r;
    lsu_pkg::aguReq_t reqs [Lanes];
    for (int it = 0; it < 8; it++) begin
      @(posedge iClk);
      for (int l = 0; l < Lanes; l++) begin
        rngState      = xorshift32(rngState);
        r             = '0;
        r.readEnable  = (rngState[1:0] == 2'd1);
        r.writeEnable = rngState[1];                    // 2 and 3 store and 0 idles
        r.byteSelect  = rngState[7:4];
        r.addr        = randomAddr(rngState[9:8]);
        r.storeData   = xorshift32(rngState);
        if (l == 0 && it == 0) begin
          r.writeEnable = 1'b1;                         // cp store passes through
          r.readEnable  = 1'b0;
        end
        reqs[l] = r;
        setReq(l, r);
      end
      @(negedge iClk);
      for (int l = 0; l < Lanes; l++)
        checkDmemReq($sformatf("requestDecode lane %0d", l), expectedDmem(reqs[l], 1'b0),
                     dmemLane[l]);
    end
    @(posedge iClk);
    for (int l = 0; l < Lanes; l++)
      setReq(l, '0);
    endTest("requestDecode");
  endtask

  task automatic testLoadAlign;
    logic [31:0] a;
    for (int lane = 0; lane < Lanes; lane++) begin
      for (int o = 0; o < 3; o++) begin
        for (int off = 0; off < 4; off++) begin
          a           = randomAddr(2'(off));
          burstReq[0] = makeLoad(opFor(o), a);
          burstExp[0] = expectedLoad(mem[lane][a[2 +: `LSU_RAM_ADDR_BITS]], opFor(o), 2'(off));
          loadBurst(lane, 1, $sformatf("loadAlign lane %0d", lane));
        end
      end
      // back to back with a new opcode every cycle
      for (int k = 0; k < 4; k++) begin
        a           = randomAddr(2'(k));
        burstReq[k] = makeLoad(opFor(k + lane), a);
        burstExp[k] = expectedLoad(mem[lane][a[2 +: `LSU_RAM_ADDR_BITS]], opFor(k + lane),
                                   2'(k));
      end
      loadBurst(lane, 4, $sformatf("loadAlign burst lane %0d", lane));
    end
    endTest("loadAlign");
  endtask

  task automatic testSpecialWrite;
    logic [31:0] data;
    rngState = xorshift32(rngState);
    data     = rngState;
    data[1:0] = expFirst ^ {data[1], 1'b1};            // always a new mode
    specialStore(`LSU_BOUNDARY_FIRST_ADDR, data);
    rngState = xorshift32(rngState);
    data     = rngState;
    data[1:0] = expLast ^ {data[1], 1'b1};
    specialStore(`LSU_BOUNDARY_LAST_ADDR, data);
    // both modes now have bit 0 set, so low bits 00 would show up in either
    specialStore(8'h10, 32'hffff_fffc);                // unmapped offset changes nothing
    endTest("specialWrite");
  endtask

  task automatic testSpecialRead;
    logic [31:0] a;
    specialStore(`LSU_BOUNDARY_FIRST_ADDR, 32'h0000_0001);
    specialStore(`LSU_BOUNDARY_LAST_ADDR, 32'h0000_0002);
    burstReq[0] = makeLoad(lsu_pkg::opWord, {`LSU_SPECIAL_PAGE, `LSU_BOUNDARY_FIRST_ADDR});
    burstExp[0] = 32'(expFirst);
    burstReq[1] = makeLoad(lsu_pkg::opWord, {`LSU_SPECIAL_PAGE, `LSU_BOUNDARY_LAST_ADDR});
    burstExp[1] = 32'(expLast);
    burstReq[2] = makeLoad(lsu_pkg::opWord, {`LSU_SPECIAL_PAGE, 8'h40});
    burstExp[2] = 32'(expLast);                         // unmapped reads the last mode
    loadBurst(0, 3, "specialRead cp");
    // pe lanes have no page so the same address is plain memory
    a = {`LSU_SPECIAL_PAGE, `LSU_BOUNDARY_FIRST_ADDR};
    for (int lane = 1; lane < Lanes; lane++) begin
      burstReq[0] = makeLoad(lsu_pkg::opWord, a);
      burstExp[0] = mem[lane][a[2 +: `LSU_RAM_ADDR_BITS]];
      loadBurst(lane, 1, $sformatf("specialRead pe lane %0d", lane));
    end
    endTest("specialRead");
  endtask

  initial begin
    rngState    = 32'h5a85;
    testErrors  = 0;
    totalErrors = 0;
    testsRun    = 0;
    testsFailed = 0;
    expFirst    = `LSU_BOUNDARY_ZERO;
    expLast     = `LSU_BOUNDARY_ZERO;
    for (int l = 0; l < Lanes; l++) begin
      for (int a = 0; a < (1 << `LSU_RAM_ADDR_BITS); a++) begin
        rngState = xorshift32(rngState);
        mem[l][a] = rngState;
      end
    end
    rstN  <= 1'b0;
    cpReq <= '0;
    for (int i = 0; i < `LSU_NUM_PE; i++)
      peReq[i] <= '0;
    repeat (4) @(posedge iClk);
    rstN <= 1'b1;

    testReset();
    testRequestDecode();
    testLoadAlign();
    testSpecialWrite();
    testSpecialRead();

    $display("tests run %0d, failing %0d, mismatches %0d", testsRun, testsFailed, totalErrors);
    if (testsFailed == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
